/* rtl/cache_geom_pkg.sv */
// geometry is fixed at 2 KiB, 2-way, 16-byte blocks and 16-bit words; changing one value alone breaks the field split
package cache_geom_pkg;

  localparam int word_w          = 16;  // data word width
  localparam int addr_w          = 16;  // byte address width
  localparam int sets            = 64;
  localparam int ways            = 2;   // hit_way and lru logic assume exactly two
  localparam int words_per_block = 8;   // also the fill burst length

  // field widths of a byte address
  localparam int tag_w = 6;
  localparam int set_w = 6;
  localparam int off_w = 3;

  // address split, msb first: tag 15..10, set 9..4, word 3..1, byte 0
  typedef struct packed {
    logic [tag_w-1:0] tag;
    logic [set_w-1:0] set;
    logic [off_w-1:0] word;
    logic             byte_sel;  // ignored, word access only
  } cache_addr_t;

endpackage

/* rtl/cache_bus_pkg.sv */
// request and fill structs between processor, caches and arbiter; requests are held until answered
package cache_bus_pkg;
  import cache_geom_pkg::*;

  // processor to cache, held stable until ready
  typedef struct packed {
    logic              valid;
    logic              write;   // ignored by the instruction cache
    cache_addr_t       addr;
    logic [word_w-1:0] wdata;
  } cpu_req_t;

  // cache to processor, ready is a one-cycle pulse
  typedef struct packed {
    logic              ready;
    logic [word_w-1:0] rdata;
  } cpu_resp_t;

  // cache to arbiter, block-aligned addr for reads, word addr for writes
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [addr_w-1:0] addr;
    logic [word_w-1:0] wdata;
  } mem_req_t;

  // arbiter to cache, one beat per apb transfer; write done has valid low
  typedef struct packed {
    logic              valid;
    logic              done;
    logic [off_w-1:0]  word;
    logic [word_w-1:0] data;
  } fill_t;

endpackage

/* rtl/cache_tag_array.sv */
// valid/tag/lru store; combinational lookup, so lookup_addr must stay stable across a request
`timescale 1ns/1ps

module cache_tag_array
  import cache_geom_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  cache_addr_t lookup_addr,
  output logic        hit,
  output logic        hit_way,   // valid only with hit
  output logic        lru_way,   // victim way of the looked-up set
  input  logic        touch,     // make hit_way most recent
  input  logic        fill,      // install lookup tag into fill_way
  input  logic        fill_way
);

  logic [sets-1:0][ways-1:0] valid_q;
  logic [sets-1:0]           lru_q;     // 1 -> way 1 is the victim
  logic [tag_w-1:0]          tag_q [sets][ways];
  logic [ways-1:0]           way_hit;

  // compare both ways of the selected set
  always_comb begin
    for (int w = 0; w < ways; w++) begin
      way_hit[w] = valid_q[lookup_addr.set][w] &&
                   (tag_q[lookup_addr.set][w] == lookup_addr.tag);
    end
  end

  assign hit     = |way_hit;
  assign hit_way = way_hit[1];  // a tag lives in at most one way
  assign lru_way = lru_q[lookup_addr.set];

  // control state, cleared at reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
      lru_q   <= '0;
    end else begin
      if (fill) begin
        valid_q[lookup_addr.set][fill_way] <= 1'b1;
        lru_q[lookup_addr.set]             <= ~fill_way;  // new block is most recent
      end else if (touch) begin
        lru_q[lookup_addr.set] <= ~hit_way;  // the other way becomes the victim
      end
    end
  end

  // tag store, written on fill only
  always_ff @(posedge clk) begin
    if (fill) begin
      tag_q[lookup_addr.set][fill_way] <= lookup_addr.tag;
    end
  end

endmodule

/* rtl/cache_data_array.sv */
// one way of block data, single port; a read in the cycle of a write to the same word returns old data
`timescale 1ns/1ps

module cache_data_array
  import cache_geom_pkg::*;
(
  input  logic              clk,
  input  logic [set_w-1:0]  set,
  input  logic [off_w-1:0]  word,
  input  logic              we,
  input  logic [word_w-1:0] wdata,
  output logic [word_w-1:0] rdata   // one cycle after the address
);

  localparam int depth = sets * words_per_block;

  logic [word_w-1:0]      mem [depth];
  logic [set_w+off_w-1:0] idx;

  assign idx = {set, word};  // block-major word index

  always_ff @(posedge clk) begin
    if (we) begin
      mem[idx] <= wdata;
    end
    rdata <= mem[idx];  // read every cycle
  end

endmodule

/* rtl/l1_cache.sv */
// one 2-way cache; read miss refills the lru way, writes go through to memory without allocate when allow_write is set
`timescale 1ns/1ps

module l1_cache
  import cache_geom_pkg::*, cache_bus_pkg::*;
#(
  parameter bit allow_write = 1'b1  // 0 turns writes into reads (instruction side)
) (
  input  logic      clk,
  input  logic      arst_n,
  input  cpu_req_t  cpu_req,
  output cpu_resp_t cpu_resp,
  output mem_req_t  mem_req,
  input  fill_t     fill
);

  typedef enum logic [1:0] {st_idle, st_lookup, st_mem, st_resp} state_t;

  state_t            state_q, state_d;
  logic              is_write;
  logic              hit, hit_way, lru_way;
  logic              touch, fill_tag, fill_wr, wr_hit;
  logic              we0, we1;
  logic [off_w-1:0]  arr_word;
  logic [word_w-1:0] arr_wdata, rd0, rd1, rdata_q;
  cache_addr_t       blk_addr;

  assign is_write = allow_write && cpu_req.write;

  assign touch    = (state_q == st_lookup) && hit;              // read or write hit
  assign wr_hit   = (state_q == st_lookup) && hit && is_write;
  assign fill_wr  = (state_q == st_mem) && fill.valid;          // only read bursts carry beats
  assign fill_tag = (state_q == st_mem) && fill.done && !is_write;

  // beats go to the victim way, write hits to the hit way
  assign we0       = (wr_hit && !hit_way) || (fill_wr && !lru_way);
  assign we1       = (wr_hit && hit_way) || (fill_wr && lru_way);
  assign arr_word  = fill_wr ? fill.word : cpu_req.addr.word;
  assign arr_wdata = fill_wr ? fill.data : cpu_req.wdata;

  cache_tag_array u_tags (
    .clk         (clk),
    .arst_n      (arst_n),
    .lookup_addr (cpu_req.addr),
    .hit         (hit),
    .hit_way     (hit_way),
    .lru_way     (lru_way),
    .touch       (touch),
    .fill        (fill_tag),
    .fill_way    (lru_way)
  );

  cache_data_array u_way0 (
    .clk   (clk),
    .set   (cpu_req.addr.set),
    .word  (arr_word),
    .we    (we0),
    .wdata (arr_wdata),
    .rdata (rd0)
  );

  cache_data_array u_way1 (
    .clk   (clk),
    .set   (cpu_req.addr.set),
    .word  (arr_word),
    .we    (we1),
    .wdata (arr_wdata),
    .rdata (rd1)
  );

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle:   if (cpu_req.valid) state_d = st_lookup;  // array read launched here
      st_lookup: state_d = (hit && !is_write) ? st_idle : st_mem;
      st_mem:    if (fill.done) state_d = st_resp;
      default:   state_d = st_idle;  // st_resp
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) state_q <= st_idle;
    else         state_q <= state_d;
  end

  // keep the requested word as it streams past
  always_ff @(posedge clk) begin
    if (fill_wr && (fill.word == cpu_req.addr.word)) begin
      rdata_q <= fill.data;
    end
  end

  always_comb begin
    blk_addr      = cpu_req.addr;
    blk_addr.word = '0;   // bursts start at word 0
    blk_addr.byte_sel = 1'b0;
    mem_req.valid = (state_q == st_mem);  // held until done
    mem_req.write = is_write;
    mem_req.addr  = is_write ? cpu_req.addr : blk_addr;
    mem_req.wdata = cpu_req.wdata;
  end

  // read hit answers in lookup, everything else from st_resp
  assign cpu_resp.ready = ((state_q == st_lookup) && hit && !is_write) || (state_q == st_resp);
  assign cpu_resp.rdata = (state_q == st_resp) ? rdata_q : (hit_way ? rd1 : rd0);

endmodule

/* rtl/mem_fill_arbiter.sv */
// apb master for both caches, data cache wins ties, no preemption; reads are 8 back-to-back beats, writes one transfer
`timescale 1ns/1ps

module mem_fill_arbiter
  import cache_geom_pkg::*, cache_bus_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  mem_req_t          dreq,
  input  mem_req_t          ireq,
  output fill_t             dfill,
  output fill_t             ifill,
  output logic              psel,
  output logic              penable,
  output logic              pwrite,
  output logic [addr_w-1:0] paddr,
  output logic [word_w-1:0] pwdata,
  input  logic [word_w-1:0] prdata,
  input  logic              pready
);

  typedef enum logic [1:0] {ab_idle, ab_setup, ab_access} ab_state_t;

  ab_state_t        state_q;
  logic             gnt_d_q;   // 1 -> data cache owns the bus
  logic [off_w-1:0] beat_q;
  mem_req_t         cur;
  logic             xfer_end, last;
  cache_addr_t      beat_addr;
  fill_t            beat;

  assign cur      = gnt_d_q ? dreq : ireq;  // owner holds its request until done
  assign xfer_end = (state_q == ab_access) && pready;
  assign last     = cur.write || (beat_q == off_w'(words_per_block - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ab_idle;
      gnt_d_q <= 1'b0;
      beat_q  <= '0;
    end else begin
      case (state_q)
        ab_idle: begin
          beat_q <= '0;
          if (dreq.valid) begin          // fixed priority
            gnt_d_q <= 1'b1;
            state_q <= ab_setup;
          end else if (ireq.valid) begin
            gnt_d_q <= 1'b0;
            state_q <= ab_setup;
          end
        end
        ab_setup: state_q <= ab_access;
        default: begin                   // ab_access, pready low stretches it
          if (pready) begin
            if (last) begin
              state_q <= ab_idle;
            end else begin
              beat_q  <= beat_q + 1'b1;
              state_q <= ab_setup;       // psel stays high between beats
            end
          end
        end
      endcase
    end
  end

  // reads walk the words of the block, writes keep their word address
  always_comb begin
    beat_addr = cache_addr_t'(cur.addr);
    if (!cur.write) beat_addr.word = beat_q;
  end

  assign psel    = (state_q != ab_idle);
  assign penable = (state_q == ab_access);
  assign pwrite  = cur.write;
  assign paddr   = beat_addr;
  assign pwdata  = cur.wdata;

  // completed beat, steered to the owner only
  always_comb begin
    beat.valid = xfer_end && !cur.write;
    beat.done  = xfer_end && last;   // bare done for a write
    beat.word  = beat_q;
    beat.data  = prdata;
  end

  assign dfill = gnt_d_q ? beat : '0;
  assign ifill = gnt_d_q ? '0 : beat;

endmodule

/* rtl/cache_sys.sv */
// split instruction/data cache pair sharing one apb master; the slave must eventually raise pready
`timescale 1ns/1ps

module cache_sys
  import cache_geom_pkg::*, cache_bus_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  cpu_req_t          icpu_req,   // fetch side, write ignored
  output cpu_resp_t         icpu_resp,
  input  cpu_req_t          dcpu_req,
  output cpu_resp_t         dcpu_resp,
  output logic              psel,
  output logic              penable,
  output logic              pwrite,
  output logic [addr_w-1:0] paddr,
  output logic [word_w-1:0] pwdata,
  input  logic [word_w-1:0] prdata,
  input  logic              pready
);

  mem_req_t ireq, dreq;    // cache requests to the arbiter
  fill_t    ifill, dfill;  // beats and done back

  l1_cache #(.allow_write(1'b0)) icache (
    .clk      (clk),
    .arst_n   (arst_n),
    .cpu_req  (icpu_req),
    .cpu_resp (icpu_resp),
    .mem_req  (ireq),
    .fill     (ifill)
  );

  l1_cache #(.allow_write(1'b1)) dcache (
    .clk      (clk),
    .arst_n   (arst_n),
    .cpu_req  (dcpu_req),
    .cpu_resp (dcpu_resp),
    .mem_req  (dreq),
    .fill     (dfill)
  );

  mem_fill_arbiter u_arb (
    .clk     (clk),
    .arst_n  (arst_n),
    .dreq    (dreq),
    .ireq    (ireq),
    .dfill   (dfill),
    .ifill   (ifill),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready)
  );

endmodule

/* sim/cache_sys_asserts.sv */
// bound into cache_sys; checks apb phase order and ready pulses only while arst_n is high
`timescale 1ns/1ps

module cache_sys_asserts
  import cache_geom_pkg::*, cache_bus_pkg::*;
(
  input logic              clk,
  input logic              arst_n,
  input logic              psel,
  input logic              penable,
  input logic              pready,
  input logic [addr_w-1:0] paddr,
  input cpu_resp_t         icpu_resp,
  input cpu_resp_t         dcpu_resp
);

  int errors = 0;  // failed assertion count

  // access phase entered only from a setup cycle
  penable_after_setup: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(penable) |-> $past(psel))
    else begin
      $error("penable rose without a setup phase");
      errors++;
    end

  // setup is always followed by access at the same address
  setup_then_access: assert property (@(posedge clk) disable iff (!arst_n)
    (psel && !penable) |=> (psel && penable && $stable(paddr)))
    else begin
      $error("setup phase not followed by access");
      errors++;
    end

  // wait states keep the access phase and its address
  wait_holds_addr: assert property (@(posedge clk) disable iff (!arst_n)
    (penable && !pready) |=> (penable && $stable(paddr)))
    else begin
      $error("paddr or penable moved during wait");
      errors++;
    end

  // one-cycle ready pulse per request on each port
  iready_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    icpu_resp.ready |=> !icpu_resp.ready)
    else begin
      $error("icache ready longer than one cycle");
      errors++;
    end

  dready_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    dcpu_resp.ready |=> !dcpu_resp.ready)
    else begin
      $error("dcache ready longer than one cycle");
      errors++;
    end

endmodule

bind cache_sys cache_sys_asserts u_asserts (.*);

/* sim/cache_sys_tb.sv */
// stimulus and expected data come from sim/cache_sys_testdata.txt, run from the project root
`timescale 1ns/1ps

module cache_sys_tb
  import cache_geom_pkg::*, cache_bus_pkg::*;
();

  localparam int max_ops   = 32;   // lines the data file may hold
  localparam int fields    = 6;    // port, op, addr, wdata, expected, apb reads
  localparam int wait_max  = 200;  // cycles per ready wait

  logic              clk;
  logic              arst_n;
  cpu_req_t          icpu_req, dcpu_req;
  cpu_resp_t         icpu_resp, dcpu_resp;
  logic              psel, penable, pwrite, pready;
  logic [addr_w-1:0] paddr;
  logic [word_w-1:0] pwdata, prdata;

  logic [word_w-1:0] mem [2**(addr_w-1)];   // reference memory, word addressed
  logic [15:0]       td [max_ops*fields];   // raw data file words
  logic [addr_w-1:0] rd_log[$];             // paddr of each finished apb read
  logic [addr_w-1:0] wr_addr_log[$];
  logic [word_w-1:0] wr_data_log[$];
  integer            seed;
  int                wait_cnt;
  int                n;
  logic [15:0]       port, op, addr, wdata, expv, reads;

  cache_sys dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .icpu_req  (icpu_req),
    .icpu_resp (icpu_resp),
    .dcpu_req  (dcpu_req),
    .dcpu_resp (dcpu_resp),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready)
  );

  always #10 clk = ~clk;  // 20 ns period

  // apb slave with 0 to 3 random wait states per transfer
  always @(posedge clk) begin
    if (psel && !penable) begin                 // setup seen, pick the wait
      wait_cnt = $unsigned($random(seed)) % 4;
      if (wait_cnt == 0) begin
        pready <= 1'b1;
        prdata <= mem[paddr[addr_w-1:1]];
      end
    end else if (psel && penable && !pready) begin
      if (wait_cnt <= 1) begin
        pready <= 1'b1;
        prdata <= mem[paddr[addr_w-1:1]];
      end
      wait_cnt = wait_cnt - 1;
    end else if (psel && penable && pready) begin  // transfer ends on this edge
      pready <= 1'b0;
      if (pwrite) begin
        mem[paddr[addr_w-1:1]] = pwdata;
        wr_addr_log.push_back(paddr);
        wr_data_log.push_back(pwdata);
      end else begin
        rd_log.push_back(paddr);
      end
    end
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  // a failed protocol assertion ends the run at once
  always @(negedge clk) begin
    if (dut.u_asserts.errors != 0) begin
      stop_run("a protocol assertion on the apb bus or a ready pulse failed");
    end
  end

  task automatic check_resp(input string name, input cpu_resp_t got,
                            input logic [word_w-1:0] exp);
    if (got.rdata !== exp) begin
      stop_run($sformatf("mismatch at %0t: %s got %h expected %h",
                         $time, name, got.rdata, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_paddr(input logic [addr_w-1:0] got, input logic [addr_w-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: paddr got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_pwdata(input logic [word_w-1:0] got, input logic [word_w-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: pwdata got %h expected %h", $time, got, exp));
    end
  endtask

  // a refill reads the whole block in word order 0 to 7
  task automatic check_burst(input int first, input logic [addr_w-1:0] a);
    logic [addr_w-1:0] exp;
    for (int i = 0; i < words_per_block; i++) begin
      exp = {a[addr_w-1:4], 3'(i), 1'b0};
      check_paddr(rd_log[first+i], exp);
    end
  endtask

  // one processor request, held until ready, then valid drops
  task automatic run_op(input int p, input logic [15:0] o, input logic [15:0] a,
                        input logic [15:0] wd, input logic [15:0] exp);
    cpu_req_t  req;
    cpu_resp_t resp;
    int        cycles;
    req.valid = 1'b1;
    req.write = o[0];
    req.addr  = a;
    req.wdata = wd;
    @(posedge clk);
    if (p == 0) icpu_req <= req;
    else        dcpu_req <= req;
    cycles = 0;
    do begin
      @(negedge clk);  // ready and rdata settled
      resp = (p == 0) ? icpu_resp : dcpu_resp;
      cycles++;
    end while (!resp.ready && cycles < wait_max);
    if (!resp.ready) begin
      stop_run($sformatf("no ready from %s within %0d cycles for address %h",
                         (p == 0) ? "icache" : "dcache", wait_max, a));
    end
    if (!o[0]) check_resp((p == 0) ? "icpu_resp.rdata" : "dcpu_resp.rdata", resp, exp);
    @(posedge clk);
    if (p == 0) icpu_req.valid <= 1'b0;
    else        dcpu_req.valid <= 1'b0;
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    seed     = 32'h3e27539d;
    clk      = 1'b0;
    arst_n   = 1'b0;
    icpu_req = '0;
    dcpu_req = '0;
    pready   = 1'b0;
    prdata   = '0;
    wait_cnt = 0;
    for (int a = 0; a < 2**(addr_w-1); a++) begin
      mem[a] = a[15:0] ^ 16'h5a3c;  // pattern over the whole word address
    end
    for (int i = 0; i < max_ops*fields; i++) td[i] = 16'h000f;  // unread lines end the run
    $readmemh("sim/cache_sys_testdata.txt", td);
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    n = 0;
    while (n < max_ops && td[n*fields] != 16'h000f) begin
      port  = td[n*fields];
      op    = td[n*fields+1];
      addr  = td[n*fields+2];
      wdata = td[n*fields+3];
      expv  = td[n*fields+4];
      reads = td[n*fields+5];
      rd_log.delete();
      wr_addr_log.delete();
      wr_data_log.delete();
      if (port == 16'h2) begin  // icache read raced against next line's dcache op
        fork
          run_op(0, op, addr, wdata, expv);
          run_op(1, td[n*fields+7], td[n*fields+8], td[n*fields+9], td[n*fields+10]);
        join
        check_count("apb reads", rd_log.size(), reads + td[n*fields+11]);
        check_count("apb writes", wr_addr_log.size(), 0);
        check_burst(0, td[n*fields+8]);  // data side wins the tie
        check_burst(words_per_block, addr);
        n += 2;
      end else begin
        run_op(int'(port), op, addr, wdata, expv);
        check_count("apb reads", rd_log.size(), reads);
        if (reads != 0) check_burst(0, addr);
        check_count("apb writes", wr_addr_log.size(), (port == 1 && op == 1) ? 1 : 0);
        if (port == 1 && op == 1) begin   // write-through, hit or miss
          check_paddr(wr_addr_log[0], addr);
          check_pwdata(wr_data_log[0], wdata);
        end
        n += 1;
      end
    end
    repeat (2) @(posedge clk);
    if (dut.u_asserts.errors != 0) begin
      stop_run($sformatf("%0d protocol assertions failed", dut.u_asserts.errors));
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

/* cache_sys.f */
rtl/cache_geom_pkg.sv
rtl/cache_bus_pkg.sv
rtl/cache_tag_array.sv
rtl/cache_data_array.sv
rtl/l1_cache.sv
rtl/mem_fill_arbiter.sv
rtl/cache_sys.sv
sim/cache_sys_asserts.sv
sim/cache_sys_tb.sv

/* Bender.yml */
package:
  name: cache_sys

sources:
  # packages first, geometry before bus structs
  - rtl/cache_geom_pkg.sv
  - rtl/cache_bus_pkg.sv
  - rtl/cache_tag_array.sv
  - rtl/cache_data_array.sv
  - rtl/l1_cache.sv
  - rtl/mem_fill_arbiter.sv
  - rtl/cache_sys.sv
  - target: simulation
    files:
      - sim/cache_sys_asserts.sv
      - sim/cache_sys_tb.sv

/* sim/cache_sys_testdata.txt */
// port (0 icache, 1 dcache, 2 icache read started with the next line), op (0 read, 1 write)
// addr, write data, expected read data, apb reads caused; all hex, f in port ends the list
1 0 0124 0000 5aae 8
1 0 012e 0000 5aab 0
0 0 0124 0000 5aae 8
0 0 0120 0000 5aac 0
// set 5, tags 0 and 1 then tag 2 evicts tag 1
1 0 0052 0000 5a15 8
1 0 0456 0000 5817 8
1 0 0050 0000 5a14 0
1 0 085a 0000 5e11 8
1 0 0054 0000 5a16 0
1 0 0450 0000 5814 8
// write hit, then write miss without allocate
1 1 0126 beef 0000 0
1 0 0126 0000 beef 0
1 1 3a40 1234 0000 0
1 0 3a40 0000 1234 8
1 0 3a42 0000 471d 0
// simultaneous misses on both caches
2 0 2200 0000 4b3c 8
1 0 2300 0000 4bbc 8
f 0 0000 0000 0000 0
